// ==== logic/rmt_pkg.sv ====
`default_nettype none

package rmt_pkg;

	// stream beat
	localparam int DATA_WIDTH = 64;
	localparam int KEEP_WIDTH = 8;

	// packet header vector
	localparam int FIELD_WIDTH = 16;
	localparam int NUM_FIELDS = 4;
	localparam int VLAN_WIDTH = 12;

	// match-action pipeline
	localparam int NUM_STAGES = 4;
	localparam int TABLE_DEPTH = 16;
	localparam int INDEX_WIDTH = $clog2(TABLE_DEPTH);
	localparam int ACTION_WIDTH = 20;
	localparam int PKT_FIFO_DEPTH = 16;
	localparam int PHV_FIFO_DEPTH = 8;

	// AXI4-Lite map: stage in bits 7:6, entry in bits 5:2
	localparam int AXIL_ADDR_WIDTH = 8;
	localparam int AXIL_DATA_WIDTH = 32;
	localparam int STAGE_SEL_WIDTH = $clog2(NUM_STAGES);
	localparam int ADDR_STAGE_LSB = 6;
	localparam int ADDR_ENTRY_LSB = 2;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {
		op_none = 2'd0,
		op_set  = 2'd1,
		op_add  = 2'd2
	} action_op_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [KEEP_WIDTH-1:0] keep;
		logic                  last;
	} stream_beat_t;

	// field 0 sits in the low bits of the first beat
	typedef logic [NUM_FIELDS-1:0][FIELD_WIDTH-1:0] phv_t;

	typedef struct packed {
		action_op_t                    op;
		logic [$clog2(NUM_FIELDS)-1:0] field_sel;
		logic [FIELD_WIDTH-1:0]        imm;
	} action_t;

	typedef struct packed {
		logic [NUM_STAGES-1:0]  en;
		logic [INDEX_WIDTH-1:0] index;
		action_t                action;
	} table_write_t;

endpackage

`default_nettype wire

// ==== logic/vlan_filter.sv ====
`default_nettype none

module vlan_filter (
	input  wire                   clk,
	input  wire                   aresetn,
	input  wire [31:0]            vlan_drop_flags,
	input  wire rmt_pkg::stream_beat_t s_beat,
	input  wire                   s_valid,
	output logic                  s_ready,
	output rmt_pkg::stream_beat_t m_beat,
	output logic                  m_valid,
	input  wire                   m_ready
);
	import rmt_pkg::*;

	logic                  in_pkt;
	logic                  drop_pkt;
	logic [VLAN_WIDTH-1:0] vlan_id;
	logic                  drop_now;
	logic                  accept;

	assign vlan_id = s_beat.data[VLAN_WIDTH-1:0];

	// first beat decides, the rest of the packet follows the latched flag
	assign drop_now = in_pkt ? drop_pkt : vlan_drop_flags[vlan_id[4:0]];

	// dropped beats are swallowed without waiting on the output
	assign s_ready = drop_now || !m_valid || m_ready;
	assign accept = s_valid && s_ready;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			in_pkt <= 1'b0;
			drop_pkt <= 1'b0;
		end else if (accept) begin
			in_pkt <= !s_beat.last;
			drop_pkt <= drop_now;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			m_valid <= 1'b0;
		end else if (accept && !drop_now) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !drop_now)
			m_beat <= s_beat;
	end

endmodule

`default_nettype wire

// ==== logic/header_parser.sv ====
`default_nettype none

module header_parser (
	input  wire                   clk,
	input  wire                   aresetn,
	input  wire rmt_pkg::stream_beat_t s_beat,
	input  wire                   s_valid,
	output logic                  s_ready,
	output rmt_pkg::stream_beat_t pkt_beat,
	output logic                  pkt_valid,
	input  wire                   pkt_ready,
	output rmt_pkg::phv_t         phv,
	output logic                  phv_valid,
	input  wire                   phv_ready
);

	logic in_pkt;
	logic fire;

	// every beat goes to the packet FIFO
	assign pkt_beat = s_beat;

	// the PHV is the first beat cut into fields
	assign phv = s_beat.data;

	// first beat needs the FIFO and stage 0 at once
	assign s_ready = pkt_ready && (in_pkt || phv_ready);
	assign pkt_valid = s_valid && (in_pkt || phv_ready);
	assign phv_valid = s_valid && !in_pkt && pkt_ready;
	assign fire = s_valid && s_ready;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			in_pkt <= 1'b0;
		end else if (fire) begin
			in_pkt <= !s_beat.last;
		end
	end

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  wire             clk,
	input  wire             aresetn,
	input  wire [WIDTH-1:0] din,
	input  wire             din_valid,
	output logic            din_ready,
	output logic [WIDTH-1:0] dout,
	output logic            dout_valid,
	input  wire             dout_ready
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       push;
	logic                       pop;

	assign din_ready = (int'(count) != DEPTH);
	assign dout_valid = (count != '0);
	assign push = din_valid && din_ready;
	assign pop = dout_valid && dout_ready;

	// head word falls through without a read cycle
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/match_action_stage.sv ====
`default_nettype none

module match_action_stage #(
	parameter int STAGE_ID = 0
) (
	input  wire                  clk,
	input  wire                  aresetn,
	input  wire rmt_pkg::phv_t   phv_in,
	input  wire                  in_valid,
	output logic                 in_ready,
	output rmt_pkg::phv_t        phv_out,
	output logic                 out_valid,
	input  wire                  out_ready,
	input  wire rmt_pkg::table_write_t tbl_wr,
	input  wire [rmt_pkg::INDEX_WIDTH-1:0] rd_index,
	output rmt_pkg::action_t     rd_entry
);
	import rmt_pkg::*;

	action_t               action_table [TABLE_DEPTH];
	logic [VLAN_WIDTH-1:0] vlan_id;
	action_t               act;
	phv_t                  phv_next;
	logic                  load;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			// every entry starts as op_none
			for (int i = 0; i < TABLE_DEPTH; i++)
				action_table[i] <= '0;
		end else if (tbl_wr.en[STAGE_ID]) begin
			action_table[tbl_wr.index] <= tbl_wr.action;
		end
	end

	assign rd_entry = action_table[rd_index];

	// lookup by the VLAN id the PHV carries right now
	assign vlan_id = phv_in[0][VLAN_WIDTH-1:0];
	assign act = action_table[vlan_id[INDEX_WIDTH-1:0]];

	always_comb begin
		phv_next = phv_in;
		case (act.op)
			op_set: phv_next[act.field_sel] = act.imm;
			op_add: phv_next[act.field_sel] = phv_in[act.field_sel] + act.imm;
			default: ;
		endcase
	end

	// elastic register, refills in the same cycle it drains
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			phv_out <= phv_next;
	end

endmodule

`default_nettype wire

// ==== logic/header_deparser.sv ====
`default_nettype none

module header_deparser (
	input  wire                   clk,
	input  wire                   aresetn,
	input  wire rmt_pkg::stream_beat_t pkt_beat,
	input  wire                   pkt_valid,
	output logic                  pkt_ready,
	input  wire rmt_pkg::phv_t    phv,
	input  wire                   phv_valid,
	output logic                  phv_ready,
	output rmt_pkg::stream_beat_t m_beat,
	output logic                  m_valid,
	input  wire                   m_ready
);

	logic in_pkt;
	logic out_free;
	logic fire;

	assign out_free = !m_valid || m_ready;

	// a first beat waits for its PHV, later beats only for room
	assign fire = pkt_valid && out_free && (in_pkt || phv_valid);
	assign pkt_ready = fire;
	assign phv_ready = fire && !in_pkt;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			in_pkt <= 1'b0;
		end else if (fire) begin
			in_pkt <= !pkt_beat.last;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			m_valid <= 1'b0;
		end else if (fire) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	// PHV overwrites the whole first beat, keep and last come from the packet
	always_ff @(posedge clk) begin
		if (fire) begin
			m_beat.data <= in_pkt ? pkt_beat.data : phv;
			m_beat.keep <= pkt_beat.keep;
			m_beat.last <= pkt_beat.last;
		end
	end

endmodule

`default_nettype wire

// ==== logic/table_config.sv ====
`default_nettype none

module table_config (
	input  wire                                 clk,
	input  wire                                 aresetn,
	input  wire [rmt_pkg::AXIL_ADDR_WIDTH-1:0]  awaddr,
	input  wire                                 awvalid,
	output logic                                awready,
	input  wire [rmt_pkg::AXIL_DATA_WIDTH-1:0]  wdata,
	input  wire                                 wvalid,
	output logic                                wready,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  wire                                 bready,
	input  wire [rmt_pkg::AXIL_ADDR_WIDTH-1:0]  araddr,
	input  wire                                 arvalid,
	output logic                                arready,
	output logic [rmt_pkg::AXIL_DATA_WIDTH-1:0] rdata,
	output logic [1:0]                          rresp,
	output logic                                rvalid,
	input  wire                                 rready,
	output rmt_pkg::table_write_t               tbl_wr,
	output logic [rmt_pkg::INDEX_WIDTH-1:0]     rd_index,
	input  wire rmt_pkg::action_t               rd_entries [rmt_pkg::NUM_STAGES]
);
	import rmt_pkg::*;

	logic                       wr_go;
	logic                       rd_go;
	logic [STAGE_SEL_WIDTH-1:0] wr_stage;
	logic [STAGE_SEL_WIDTH-1:0] rd_stage;
	logic [NUM_STAGES-1:0]      wr_onehot;
	logic [ACTION_WIDTH-1:0]    rd_word;

	// write: address and data are taken together, one per response
	assign wr_go = awvalid && wvalid && !bvalid;
	assign awready = wr_go;
	assign wready = wr_go;
	assign bresp = RESP_OKAY;

	assign wr_stage = awaddr[ADDR_STAGE_LSB +: STAGE_SEL_WIDTH];

	always_comb begin
		wr_onehot = '0;
		wr_onehot[wr_stage] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			tbl_wr <= '0;
			bvalid <= 1'b0;
		end else begin
			tbl_wr.en <= wr_go ? wr_onehot : '0;
			if (wr_go) begin
				tbl_wr.index <= awaddr[ADDR_ENTRY_LSB +: INDEX_WIDTH];
				tbl_wr.action <= action_t'(wdata[ACTION_WIDTH-1:0]);
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// read: every stage shows the same index, pick one by address
	assign arready = !rvalid;
	assign rd_go = arvalid && arready;
	assign rd_stage = araddr[ADDR_STAGE_LSB +: STAGE_SEL_WIDTH];
	assign rd_index = araddr[ADDR_ENTRY_LSB +: INDEX_WIDTH];
	assign rd_word = rd_entries[rd_stage];
	assign rresp = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			rvalid <= 1'b0;
		end else if (rd_go) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go)
			rdata <= {{(AXIL_DATA_WIDTH - ACTION_WIDTH){1'b0}}, rd_word};
	end

endmodule

`default_nettype wire

// ==== logic/rmt_pipeline.sv ====
`default_nettype none

module rmt_pipeline (
	input  wire                                 clk,
	input  wire                                 aresetn,
	input  wire [31:0]                          vlan_drop_flags,
	input  wire [rmt_pkg::DATA_WIDTH-1:0]       s_axis_tdata,
	input  wire [rmt_pkg::KEEP_WIDTH-1:0]       s_axis_tkeep,
	input  wire                                 s_axis_tlast,
	input  wire                                 s_axis_tvalid,
	output logic                                s_axis_tready,
	output logic [rmt_pkg::DATA_WIDTH-1:0]      m_axis_tdata,
	output logic [rmt_pkg::KEEP_WIDTH-1:0]      m_axis_tkeep,
	output logic                                m_axis_tlast,
	output logic                                m_axis_tvalid,
	input  wire                                 m_axis_tready,
	input  wire [rmt_pkg::AXIL_ADDR_WIDTH-1:0]  awaddr,
	input  wire                                 awvalid,
	output logic                                awready,
	input  wire [rmt_pkg::AXIL_DATA_WIDTH-1:0]  wdata,
	input  wire                                 wvalid,
	output logic                                wready,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  wire                                 bready,
	input  wire [rmt_pkg::AXIL_ADDR_WIDTH-1:0]  araddr,
	input  wire                                 arvalid,
	output logic                                arready,
	output logic [rmt_pkg::AXIL_DATA_WIDTH-1:0] rdata,
	output logic [1:0]                          rresp,
	output logic                                rvalid,
	input  wire                                 rready
);
	import rmt_pkg::*;

	stream_beat_t           in_beat;
	logic                   intake_open;
	logic                   filt_s_ready;
	stream_beat_t           filt_beat;
	logic                   filt_valid;
	logic                   filt_ready;
	stream_beat_t           pkt_beat;
	logic                   pkt_valid;
	logic                   pkt_ready;
	stream_beat_t           pkt_head;
	logic                   pkt_head_valid;
	logic                   pkt_head_ready;
	phv_t                   stage_phv [NUM_STAGES+1];
	logic [NUM_STAGES:0]    stage_valid;
	logic [NUM_STAGES:0]    stage_ready;
	phv_t                   phv_head;
	logic                   phv_head_valid;
	logic                   phv_head_ready;
	stream_beat_t           out_beat;
	table_write_t           tbl_wr;
	logic [INDEX_WIDTH-1:0] rd_index;
	action_t                stage_entries [NUM_STAGES];

	assign in_beat = '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast};

	// intake stops while either FIFO is full
	assign intake_open = pkt_ready && stage_ready[NUM_STAGES];
	assign s_axis_tready = filt_s_ready && intake_open;

	vlan_filter i_vlan_filter (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_beat          (in_beat),
		.s_valid         (s_axis_tvalid && intake_open),
		.s_ready         (filt_s_ready),
		.m_beat          (filt_beat),
		.m_valid         (filt_valid),
		.m_ready         (filt_ready)
	);

	header_parser i_header_parser (
		.clk       (clk),
		.aresetn   (aresetn),
		.s_beat    (filt_beat),
		.s_valid   (filt_valid),
		.s_ready   (filt_ready),
		.pkt_beat  (pkt_beat),
		.pkt_valid (pkt_valid),
		.pkt_ready (pkt_ready),
		.phv       (stage_phv[0]),
		.phv_valid (stage_valid[0]),
		.phv_ready (stage_ready[0])
	);

	sync_fifo #(
		.WIDTH ($bits(stream_beat_t)),
		.DEPTH (PKT_FIFO_DEPTH)
	) i_pkt_fifo (
		.clk        (clk),
		.aresetn    (aresetn),
		.din        (pkt_beat),
		.din_valid  (pkt_valid),
		.din_ready  (pkt_ready),
		.dout       (pkt_head),
		.dout_valid (pkt_head_valid),
		.dout_ready (pkt_head_ready)
	);

	for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
		match_action_stage #(
			.STAGE_ID (g)
		) i_stage (
			.clk       (clk),
			.aresetn   (aresetn),
			.phv_in    (stage_phv[g]),
			.in_valid  (stage_valid[g]),
			.in_ready  (stage_ready[g]),
			.phv_out   (stage_phv[g+1]),
			.out_valid (stage_valid[g+1]),
			.out_ready (stage_ready[g+1]),
			.tbl_wr    (tbl_wr),
			.rd_index  (rd_index),
			.rd_entry  (stage_entries[g])
		);
	end

	sync_fifo #(
		.WIDTH ($bits(phv_t)),
		.DEPTH (PHV_FIFO_DEPTH)
	) i_phv_fifo (
		.clk        (clk),
		.aresetn    (aresetn),
		.din        (stage_phv[NUM_STAGES]),
		.din_valid  (stage_valid[NUM_STAGES]),
		.din_ready  (stage_ready[NUM_STAGES]),
		.dout       (phv_head),
		.dout_valid (phv_head_valid),
		.dout_ready (phv_head_ready)
	);

	header_deparser i_header_deparser (
		.clk       (clk),
		.aresetn   (aresetn),
		.pkt_beat  (pkt_head),
		.pkt_valid (pkt_head_valid),
		.pkt_ready (pkt_head_ready),
		.phv       (phv_head),
		.phv_valid (phv_head_valid),
		.phv_ready (phv_head_ready),
		.m_beat    (out_beat),
		.m_valid   (m_axis_tvalid),
		.m_ready   (m_axis_tready)
	);

	assign m_axis_tdata = out_beat.data;
	assign m_axis_tkeep = out_beat.keep;
	assign m_axis_tlast = out_beat.last;

	table_config i_table_config (
		.clk        (clk),
		.aresetn    (aresetn),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.tbl_wr     (tbl_wr),
		.rd_index   (rd_index),
		.rd_entries (stage_entries)
	);

endmodule

`default_nettype wire

// ==== verification/rmt_pipeline_assertions.sv ====
`default_nettype none

module rmt_pipeline_assertions (
	input wire                                 clk,
	input wire                                 aresetn,
	input wire [rmt_pkg::DATA_WIDTH-1:0]       m_axis_tdata,
	input wire [rmt_pkg::KEEP_WIDTH-1:0]       m_axis_tkeep,
	input wire                                 m_axis_tlast,
	input wire                                 m_axis_tvalid,
	input wire                                 m_axis_tready,
	input wire [1:0]                           bresp,
	input wire                                 bvalid,
	input wire                                 bready,
	input wire [rmt_pkg::AXIL_DATA_WIDTH-1:0]  rdata,
	input wire [1:0]                           rresp,
	input wire                                 rvalid,
	input wire                                 rready
);
	timeunit 1ns;
	timeprecision 1ps;
	import rmt_pkg::*;

	int failures = 0;

	// synchronous reset clears every valid on the next edge
	a_reset_idle: assert property (@(posedge clk)
		!aresetn |=> !m_axis_tvalid && !bvalid && !rvalid)
	else begin
		failures++;
		$error("a valid output was high after a reset cycle");
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!aresetn)
		bvalid && !bready |=> bvalid)
	else begin
		failures++;
		$error("bvalid dropped before bready");
	end

	a_bresp_okay: assert property (@(posedge clk) disable iff (!aresetn)
		bvalid |-> bresp == RESP_OKAY)
	else begin
		failures++;
		$error("write response was not OKAY");
	end

	// read data stays put until it is taken
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!aresetn)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		failures++;
		$error("read data changed or rvalid dropped before rready");
	end

	a_m_axis_stable: assert property (@(posedge clk) disable iff (!aresetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
			&& $stable(m_axis_tkeep) && $stable(m_axis_tlast))
	else begin
		failures++;
		$error("output beat changed while stalled");
	end

endmodule

`default_nettype wire

// ==== verification/rmt_pipeline_tb.sv ====
`default_nettype none

module rmt_pipeline_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rmt_pkg::*;

	localparam int NUM_PKTS = 48;
	localparam int TIMEOUT = 2000;
	localparam int DRAIN_TIMEOUT = 20000;
	localparam int CH_AW = 0;
	localparam int CH_B = 1;
	localparam int CH_AR = 2;
	localparam int CH_R = 3;
	localparam int CH_S = 4;

	logic                       clk;
	logic                       aresetn;
	logic [31:0]                vlan_drop_flags;
	logic [DATA_WIDTH-1:0]      s_axis_tdata;
	logic [KEEP_WIDTH-1:0]      s_axis_tkeep;
	logic                       s_axis_tlast;
	logic                       s_axis_tvalid;
	logic                       s_axis_tready;
	logic [DATA_WIDTH-1:0]      m_axis_tdata;
	logic [KEEP_WIDTH-1:0]      m_axis_tkeep;
	logic                       m_axis_tlast;
	logic                       m_axis_tvalid;
	logic                       m_axis_tready = 1'b0;
	logic [AXIL_ADDR_WIDTH-1:0] awaddr;
	logic                       awvalid;
	logic                       awready;
	logic [AXIL_DATA_WIDTH-1:0] wdata;
	logic                       wvalid;
	logic                       wready;
	logic [1:0]                 bresp;
	logic                       bvalid;
	logic                       bready;
	logic [AXIL_ADDR_WIDTH-1:0] araddr;
	logic                       arvalid;
	logic                       arready;
	logic [AXIL_DATA_WIDTH-1:0] rdata;
	logic [1:0]                 rresp;
	logic                       rvalid;
	logic                       rready;

	logic [31:0]             stim_rng = 32'd38869;
	logic [31:0]             rdy_rng = 32'd38869;
	logic [ACTION_WIDTH-1:0] model_tbl [NUM_STAGES][TABLE_DEPTH];
	stream_beat_t            exp_q [$];
	stream_beat_t            out_q [$];
	int                      errors = 0;
	int                      timeouts = 0;

	rmt_pipeline i_dut (.*);

	bind rmt_pipeline rmt_pipeline_assertions i_assertions (
		.clk           (clk),
		.aresetn       (aresetn),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tkeep  (m_axis_tkeep),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.bresp         (bresp),
		.bvalid        (bvalid),
		.bready        (bready),
		.rdata         (rdata),
		.rresp         (rresp),
		.rvalid        (rvalid),
		.rready        (rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// upper half of the state as the random value
	function automatic logic [15:0] next_rand();
		stim_rng = lcg(stim_rng);
		return stim_rng[31:16];
	endfunction

	function automatic logic [63:0] rand64();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	// expected first beat with each stage indexed by the VLAN id before it
	function automatic logic [63:0] model_phv(input logic [63:0] first);
		logic [15:0]             f [NUM_FIELDS];
		logic [ACTION_WIDTH-1:0] ent;
		logic [1:0]              sel;
		for (int i = 0; i < NUM_FIELDS; i++)
			f[i] = first[16*i +: 16];
		for (int s = 0; s < NUM_STAGES; s++) begin
			ent = model_tbl[s][f[0][3:0]];
			sel = ent[17:16];
			if (ent[19:18] == 2'd1)
				f[sel] = ent[15:0];
			else if (ent[19:18] == 2'd2)
				f[sel] = f[sel] + ent[15:0];
		end
		return {f[3], f[2], f[1], f[0]};
	endfunction

	function automatic logic handshake(input int ch);
		case (ch)
			CH_AW: return awready && wready;
			CH_B: return bvalid;
			CH_AR: return arready;
			CH_R: return rvalid;
			default: return s_axis_tready;
		endcase
	endfunction

	// returns at the falling edge before the transfer edge
	task automatic wait_until(input int ch, input string what);
		int t;
		t = 0;
		@(negedge clk);
		while (!handshake(ch) && t < TIMEOUT) begin
			t++;
			@(negedge clk);
		end
		if (!handshake(ch)) begin
			timeouts++;
			$display("timeout: %s never came within %0d cycles", what, TIMEOUT);
		end
	endtask

	task automatic check(input string name, input logic [63:0] want, input logic [63:0] got);
		if (got !== want) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
		logic [15:0] r;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		wait_until(CH_AW, "awready and wready");
		r = next_rand();
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// late bready makes bvalid wait
		repeat (int'(r[15:14])) @(posedge clk);
		bready <= 1'b1;
		wait_until(CH_B, "bvalid");
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic [15:0] r;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		wait_until(CH_AR, "arready");
		r = next_rand();
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (int'(r[15:14])) @(posedge clk);
		rready <= 1'b1;
		wait_until(CH_R, "rvalid");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic send_beat(input stream_beat_t beat);
		logic [15:0] r;
		r = next_rand();
		repeat (int'(r[15:14])) begin
			@(posedge clk);
			s_axis_tvalid <= 1'b0;
		end
		@(posedge clk);
		s_axis_tdata <= beat.data;
		s_axis_tkeep <= beat.keep;
		s_axis_tlast <= beat.last;
		s_axis_tvalid <= 1'b1;
		wait_until(CH_S, "s_axis_tready");
	endtask

	// output side takes about one cycle in four so the FIFOs fill up
	always @(posedge clk) begin
		rdy_rng <= lcg(rdy_rng);
		m_axis_tready <= rdy_rng[31] & rdy_rng[29];
	end

	always @(negedge clk) begin
		if (aresetn && m_axis_tvalid && m_axis_tready)
			out_q.push_back('{data: m_axis_tdata, keep: m_axis_tkeep, last: m_axis_tlast});
	end

	initial begin
		logic [7:0]   addr;
		logic [31:0]  word;
		logic [31:0]  rd_data;
		logic [1:0]   rd_resp;
		logic [15:0]  r;
		logic [15:0]  imm;
		logic [1:0]   op;
		logic [31:0]  drop_mask;
		logic         keep_pkt;
		stream_beat_t beat;
		stream_beat_t want;
		int           len;
		int           kept;
		int           out_pkts;
		int           t;

		aresetn = 1'b0;
		vlan_drop_flags = '0;
		s_axis_tdata = '0;
		s_axis_tkeep = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		kept = 0;
		keep_pkt = 1'b0;
		repeat (8) @(posedge clk);
		aresetn <= 1'b1;

		// every entry of every stage is written and read back
		for (int s = 0; s < NUM_STAGES; s++) begin
			for (int e = 0; e < TABLE_DEPTH; e++) begin
				r = next_rand();
				imm = next_rand();
				op = (r[3:2] == 2'd3) ? 2'd2 : r[3:2];
				word = {r[15:4], op, r[1:0], imm};
				addr = {2'(s), 4'(e), 2'b00};
				model_tbl[s][e] = word[ACTION_WIDTH-1:0];
				axil_write(addr, word);
				axil_read(addr, rd_data, rd_resp);
				check($sformatf("table s%0d e%0d rdata", s, e), 64'(word[19:0]), 64'(rd_data));
				check($sformatf("table s%0d e%0d rresp", s, e), 64'(RESP_OKAY), 64'(rd_resp));
			end
		end

		drop_mask = {next_rand(), next_rand()};
		@(posedge clk);
		vlan_drop_flags <= drop_mask;

		for (int p = 0; p < NUM_PKTS; p++) begin
			r = next_rand();
			len = 1 + int'(r[15:14]);
			for (int i = 0; i < len; i++) begin
				beat.data = rand64();
				r = next_rand();
				beat.keep = r[15:8];
				beat.last = (i == len - 1);
				if (i == 0)
					keep_pkt = !drop_mask[beat.data[4:0]];
				if (keep_pkt) begin
					want = beat;
					if (i == 0)
						want.data = model_phv(beat.data);
					exp_q.push_back(want);
				end
				send_beat(beat);
			end
			if (keep_pkt)
				kept++;
		end
		@(posedge clk);
		s_axis_tvalid <= 1'b0;

		t = 0;
		while (out_q.size() < exp_q.size() && t < DRAIN_TIMEOUT) begin
			t++;
			@(negedge clk);
		end
		if (out_q.size() < exp_q.size()) begin
			timeouts++;
			$display("timeout: output stalled after %0d of %0d beats", out_q.size(), exp_q.size());
		end
		// room for any beat that should have been dropped
		repeat (64) @(negedge clk);

		check("output beat count", 64'(exp_q.size()), 64'(out_q.size()));
		out_pkts = 0;
		foreach (out_q[i]) begin
			if (out_q[i].last)
				out_pkts++;
		end
		check("output packet count", 64'(kept), 64'(out_pkts));
		for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
			check($sformatf("beat %0d data", i), exp_q[i].data, out_q[i].data);
			check($sformatf("beat %0d keep", i), 64'(exp_q[i].keep), 64'(out_q[i].keep));
			check($sformatf("beat %0d last", i), 64'(exp_q[i].last), 64'(out_q[i].last));
		end

		$display("errors: %0d value, %0d timeout, %0d assertion", errors, timeouts,
			i_dut.i_assertions.failures);
		if (errors == 0 && timeouts == 0 && i_dut.i_assertions.failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rmt_pipeline.f ====
logic/rmt_pkg.sv
logic/vlan_filter.sv
logic/header_parser.sv
logic/sync_fifo.sv
logic/match_action_stage.sv
logic/header_deparser.sv
logic/table_config.sv
logic/rmt_pipeline.sv
verification/rmt_pipeline_assertions.sv
verification/rmt_pipeline_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rmt_pipeline_tb
FILELIST  := rmt_pipeline.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
